/* src/uf_macros.svh */
`ifndef UF_MACROS_SVH
`define UF_MACROS_SVH

// Number of ancilla units in the line
`define NUM_PE 8
// Width of a unit address
`define ADDR_WIDTH 3
// Left neighbor is index 0, right neighbor is index 1
`define NEIGHBOR_COUNT 2
// Merge cycles before the busy tree is trusted
`define MERGE_SETTLE 3
// Width of the grow round count
`define ROUND_WIDTH 4

`endif

/* src/uf_pkg.sv */
package uf_pkg;

    // Stage broadcast from the controller to units and edges
    typedef enum logic [2:0] {
        STAGE_IDLE  = 3'd0,
        STAGE_LOAD  = 3'd1,
        STAGE_GROW  = 3'd2,
        STAGE_MERGE = 3'd3,
        STAGE_DONE  = 3'd4
    } stage_t;

    // Edge growth in half steps, saturating at fully grown
    typedef logic [1:0] growth_t;

    localparam growth_t GROWTH_NONE = 2'd0;
    localparam growth_t GROWTH_FULL = 2'd2;

endpackage

/* src/stage_controller.sv */
`timescale 1ns/1ps

module stage_controller (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           any_busy,
    input  logic           any_odd,
    input  logic           settle_done,
    output uf_pkg::stage_t stage,
    output logic           grow_first,
    output logic           done
);
    import uf_pkg::*;

    // Second cycle of the two-cycle grow stage
    logic grow_second;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage       <= STAGE_IDLE;
            grow_second <= 1'b0;
        end else begin
            case (stage)
                STAGE_IDLE: begin
                    if (start) begin
                        stage <= STAGE_LOAD;
                    end
                end
                STAGE_LOAD: begin
                    stage <= STAGE_MERGE;
                end
                STAGE_MERGE: begin
                    // Leave only once the window has passed and all units are quiet
                    if (settle_done && !any_busy) begin
                        if (any_odd) begin
                            stage <= STAGE_GROW;
                        end else begin
                            stage <= STAGE_DONE;
                        end
                    end
                end
                STAGE_GROW: begin
                    if (grow_second) begin
                        stage       <= STAGE_MERGE;
                        grow_second <= 1'b0;
                    end else begin
                        grow_second <= 1'b1;
                    end
                end
                STAGE_DONE: begin
                    // Results stay valid until a new run is started
                    if (start) begin
                        stage <= STAGE_LOAD;
                    end
                end
                default: begin
                    stage       <= STAGE_IDLE;
                    grow_second <= 1'b0;
                end
            endcase
        end
    end

    assign grow_first = (stage == STAGE_GROW) && !grow_second;
    assign done       = (stage == STAGE_DONE);

endmodule

/* src/round_timer.sv */
`timescale 1ns/1ps

`include "uf_macros.svh"

module round_timer (
    input  logic                    clk,
    input  logic                    reset,
    input  uf_pkg::stage_t          stage,
    input  logic                    grow_first,
    output logic                    settle_done,
    output logic [`ROUND_WIDTH-1:0] grow_rounds
);
    import uf_pkg::*;

    localparam int SETTLE_WIDTH = $clog2(`MERGE_SETTLE + 1);
    localparam logic [SETTLE_WIDTH-1:0] SETTLE_LAST = `MERGE_SETTLE;

    logic [SETTLE_WIDTH-1:0] settle_count;

    // Cycles spent in the current merge phase
    always_ff @(posedge clk) begin
        if (reset) begin
            settle_count <= '0;
        end else if (stage != STAGE_MERGE) begin
            settle_count <= '0;
        end else if (settle_count != SETTLE_LAST) begin
            settle_count <= settle_count + SETTLE_WIDTH'(1);
        end
    end

    assign settle_done = (settle_count == SETTLE_LAST);

    always_ff @(posedge clk) begin
        if (reset) begin
            grow_rounds <= '0;
        end else if (stage == STAGE_LOAD) begin
            grow_rounds <= '0;
        end else if (grow_first) begin
            grow_rounds <= grow_rounds + `ROUND_WIDTH'(1);
        end
    end

endmodule

/* src/root_min_select.sv */
`timescale 1ns/1ps

`include "uf_macros.svh"

module root_min_select #(
    parameter int DATA_WIDTH    = `ADDR_WIDTH,
    parameter int CHANNEL_COUNT = `NEIGHBOR_COUNT
) (
    input  logic [CHANNEL_COUNT*DATA_WIDTH-1:0] values,
    input  logic [CHANNEL_COUNT-1:0]            valids,
    output logic [DATA_WIDTH-1:0]               result,
    output logic [CHANNEL_COUNT-1:0]            result_valids
);

    logic found;

    // Strict compare keeps the lower channel on a tie
    always_comb begin
        result        = '0;
        result_valids = '0;
        found         = 1'b0;
        for (int ch = 0; ch < CHANNEL_COUNT; ch++) begin
            if (valids[ch] && (!found || values[ch*DATA_WIDTH +: DATA_WIDTH] < result)) begin
                result            = values[ch*DATA_WIDTH +: DATA_WIDTH];
                result_valids     = '0;
                result_valids[ch] = 1'b1;
                found             = 1'b1;
            end
        end
    end

endmodule

/* src/processing_unit.sv */
`timescale 1ns/1ps

`include "uf_macros.svh"

module processing_unit #(
    parameter int ADDRESS = 0
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        measurement,
    input  uf_pkg::stage_t                              global_stage,
    input  logic [`NEIGHBOR_COUNT-1:0]                  neighbor_fully_grown,
    input  logic [`NEIGHBOR_COUNT*`ADDR_WIDTH-1:0]      neighbor_root,
    input  logic [`NEIGHBOR_COUNT-1:0]                  neighbor_parent_vector,
    input  logic [`NEIGHBOR_COUNT-1:0]                  neighbor_is_boundary,
    input  logic [`NEIGHBOR_COUNT-1:0]                  parent_odd,
    input  logic [`NEIGHBOR_COUNT-1:0]                  child_cluster_parity,
    input  logic [`NEIGHBOR_COUNT-1:0]                  child_touching_boundary,
    output logic                                        neighbor_increase,
    output logic [`NEIGHBOR_COUNT-1:0]                  parent_vector,
    output logic                                        cluster_parity,
    output logic                                        cluster_touching_boundary,
    output logic                                        odd,
    output logic [`ADDR_WIDTH-1:0]                      root,
    output logic                                        busy
);
    import uf_pkg::*;

    localparam logic [`ADDR_WIDTH-1:0] OWN_ROOT = ADDRESS[`ADDR_WIDTH-1:0];

    stage_t                     stage;
    stage_t                     last_stage;
    logic                       meas;
    logic [`ADDR_WIDTH-1:0]     min_root;
    logic [`NEIGHBOR_COUNT-1:0] min_valids;
    logic                       root_change;
    logic                       next_parity;
    logic                       next_touching;
    logic                       next_odd;

    // Local copy of the broadcast, so the unit acts one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            stage      <= STAGE_IDLE;
            last_stage <= STAGE_IDLE;
        end else begin
            stage      <= global_stage;
            last_stage <= stage;
        end
    end

    // One half step on both edges per grow stage
    assign neighbor_increase = odd && (stage == STAGE_GROW) && (last_stage != STAGE_GROW);

    // Only neighbors across a fully grown edge offer their root
    root_min_select #(
        .DATA_WIDTH   (`ADDR_WIDTH),
        .CHANNEL_COUNT(`NEIGHBOR_COUNT)
    ) u_root_min (
        .values       (neighbor_root),
        .valids       (neighbor_fully_grown),
        .result       (min_root),
        .result_valids(min_valids)
    );

    assign root_change = (|min_valids) && (min_root < root);

    // Subtree values fold in every neighbor that names this unit as parent
    assign next_parity   = (^(neighbor_parent_vector & child_cluster_parity)) ^ meas;
    assign next_touching = (|(neighbor_parent_vector & child_touching_boundary))
                         | (|neighbor_is_boundary);

    // A root decides odd itself, others follow their parent
    assign next_odd = (|parent_vector) ? (|(parent_vector & parent_odd))
                                       : (next_parity && !next_touching);

    always_ff @(posedge clk) begin
        if (reset) begin
            meas                      <= 1'b0;
            root                      <= OWN_ROOT;
            parent_vector             <= '0;
            cluster_parity            <= 1'b0;
            cluster_touching_boundary <= 1'b0;
            odd                       <= 1'b0;
        end else if (stage == STAGE_LOAD) begin
            meas                      <= measurement;
            root                      <= OWN_ROOT;
            parent_vector             <= '0;
            cluster_parity            <= measurement;
            cluster_touching_boundary <= 1'b0;
            odd                       <= measurement;
        end else if (stage == STAGE_MERGE) begin
            if (root_change) begin
                root          <= min_root;
                parent_vector <= min_valids;
            end
            cluster_parity            <= next_parity;
            cluster_touching_boundary <= next_touching;
            odd                       <= next_odd;
        end
    end

    // Busy while any merge register would still move
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else begin
            busy <= (stage == STAGE_MERGE)
                 && (root_change
                     || (next_parity != cluster_parity)
                     || (next_touching != cluster_touching_boundary)
                     || (next_odd != odd));
        end
    end

endmodule

/* src/edge_support.sv */
`timescale 1ns/1ps

module edge_support (
    input  logic           clk,
    input  logic           reset,
    input  uf_pkg::stage_t stage,
    input  logic           grow_a,
    input  logic           grow_b,
    output logic           fully_grown
);
    import uf_pkg::*;

    growth_t    growth;
    logic [2:0] growth_sum;

    // Both sides may push in the same cycle
    assign growth_sum = {1'b0, growth} + {2'b00, grow_a} + {2'b00, grow_b};

    always_ff @(posedge clk) begin
        if (reset) begin
            growth <= GROWTH_NONE;
        end else if (stage == STAGE_LOAD) begin
            growth <= GROWTH_NONE;
        end else if (growth_sum >= {1'b0, GROWTH_FULL}) begin
            growth <= GROWTH_FULL;
        end else begin
            growth <= growth_sum[1:0];
        end
    end

    assign fully_grown = (growth == GROWTH_FULL);

endmodule

/* src/decoder_array.sv */
`timescale 1ns/1ps

`include "uf_macros.svh"

module decoder_array (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  logic [`NUM_PE-1:0]                syndrome,
    output logic                              done,
    output logic [`NUM_PE*`ADDR_WIDTH-1:0]    roots,
    output logic [`NUM_PE:0]                  grown_edges,
    output logic [`ROUND_WIDTH-1:0]           grow_rounds
);
    import uf_pkg::*;

    stage_t stage;
    logic   grow_first;
    logic   settle_done;
    logic   any_busy;
    logic   any_odd;

    // Unit k sits at index k+1, both ends are padded with zeros
    wire [`NUM_PE+1:0]                   pad_increase;
    wire [`NUM_PE+1:0]                   pad_parity;
    wire [`NUM_PE+1:0]                   pad_touching;
    wire [`NUM_PE+1:0]                   pad_odd;
    wire [`NUM_PE+1:0][1:0]              pad_parent;
    wire [`NUM_PE+1:0][`ADDR_WIDTH-1:0]  pad_root;
    wire [`NUM_PE-1:0]                   pe_busy;
    wire [`NUM_PE:0]                     edge_full;

    assign pad_increase[0]         = 1'b0;
    assign pad_increase[`NUM_PE+1] = 1'b0;
    assign pad_parity[0]           = 1'b0;
    assign pad_parity[`NUM_PE+1]   = 1'b0;
    assign pad_touching[0]         = 1'b0;
    assign pad_touching[`NUM_PE+1] = 1'b0;
    assign pad_odd[0]              = 1'b0;
    assign pad_odd[`NUM_PE+1]      = 1'b0;
    assign pad_parent[0]           = '0;
    assign pad_parent[`NUM_PE+1]   = '0;
    assign pad_root[0]             = '0;
    assign pad_root[`NUM_PE+1]     = '0;

    stage_controller u_ctrl (
        .clk(clk), .reset(reset), .start(start), .any_busy(any_busy), .any_odd(any_odd),
        .settle_done(settle_done), .stage(stage), .grow_first(grow_first), .done(done)
    );

    round_timer u_timer (
        .clk(clk), .reset(reset), .stage(stage), .grow_first(grow_first),
        .settle_done(settle_done), .grow_rounds(grow_rounds)
    );

    genvar i;
    generate
        for (i = 0; i < `NUM_PE; i++) begin : g_pe
            // End edges count as boundary contact, not as a neighbor link
            processing_unit #(.ADDRESS(i)) u_pe (
                .clk                      (clk),
                .reset                    (reset),
                .measurement              (syndrome[i]),
                .global_stage             (stage),
                .neighbor_fully_grown     ({(i == `NUM_PE-1) ? 1'b0 : edge_full[i+1],
                                            (i == 0) ? 1'b0 : edge_full[i]}),
                .neighbor_root            ({pad_root[i+2], pad_root[i]}),
                .neighbor_parent_vector   ({pad_parent[i+2][0], pad_parent[i][1]}),
                .neighbor_is_boundary     ({(i == `NUM_PE-1) ? edge_full[`NUM_PE] : 1'b0,
                                            (i == 0) ? edge_full[0] : 1'b0}),
                .parent_odd               ({pad_odd[i+2], pad_odd[i]}),
                .child_cluster_parity     ({pad_parity[i+2], pad_parity[i]}),
                .child_touching_boundary  ({pad_touching[i+2], pad_touching[i]}),
                .neighbor_increase        (pad_increase[i+1]),
                .parent_vector            (pad_parent[i+1]),
                .cluster_parity           (pad_parity[i+1]),
                .cluster_touching_boundary(pad_touching[i+1]),
                .odd                      (pad_odd[i+1]),
                .root                     (pad_root[i+1]),
                .busy                     (pe_busy[i])
            );
            assign roots[i*`ADDR_WIDTH +: `ADDR_WIDTH] = pad_root[i+1];
        end

        // Edge j joins unit j-1 on side a and unit j on side b
        for (i = 0; i <= `NUM_PE; i++) begin : g_edge
            edge_support u_edge (
                .clk(clk), .reset(reset), .stage(stage), .grow_a(pad_increase[i]),
                .grow_b(pad_increase[i+1]), .fully_grown(edge_full[i])
            );
        end
    endgenerate

    assign any_busy    = |pe_busy;
    assign any_odd     = |pad_odd;
    assign grown_edges = edge_full;

endmodule

/* verification/decoder_tb.sv */
`timescale 1ns/1ps

`include "uf_macros.svh"

module decoder_tb;

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 8;
    localparam int DONE_LIMIT   = 500;
    localparam int RANDOM_RUNS  = 40;
    localparam int IDLE_CYCLES  = 40;

    logic                           clk;
    logic                           reset;
    logic                           start;
    logic [`NUM_PE-1:0]             syndrome;
    logic                           done;
    logic [`NUM_PE*`ADDR_WIDTH-1:0] roots;
    logic [`NUM_PE:0]               grown_edges;
    logic [`ROUND_WIDTH-1:0]        grow_rounds;

    // Filled in by the reference model
    logic [`NUM_PE*`ADDR_WIDTH-1:0] exp_roots;
    logic [`NUM_PE:0]               exp_edges;
    logic [`ROUND_WIDTH-1:0]        exp_rounds;

    decoder_array dut0 (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .syndrome   (syndrome),
        .done       (done),
        .roots      (roots),
        .grown_edges(grown_edges),
        .grow_rounds(grow_rounds)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    task automatic stop_on_failure;
        $display("Errors found");
        $fatal(1);
    endtask

    // Clusters on a line are runs of units joined by fully grown edges
    task automatic predict(input logic [`NUM_PE-1:0] syn);
        int   growth [`NUM_PE+1];
        int   label [`NUM_PE];
        logic parity [`NUM_PE];
        logic touch [`NUM_PE];
        logic unit_odd [`NUM_PE];
        logic growing;
        int   rounds;
        rounds  = 0;
        growing = 1'b1;
        for (int e = 0; e <= `NUM_PE; e++) begin
            growth[e] = 0;
        end
        while (growing && rounds < 16) begin
            // Leftmost unit of each run is its smallest address
            for (int k = 0; k < `NUM_PE; k++) begin
                if (k > 0 && growth[k] == 2) begin
                    label[k] = label[k-1];
                end else begin
                    label[k] = k;
                end
                parity[k] = 1'b0;
                touch[k]  = 1'b0;
            end
            for (int k = 0; k < `NUM_PE; k++) begin
                parity[label[k]] = parity[label[k]] ^ syn[k];
            end
            touch[label[0]]         = (growth[0] == 2);
            touch[label[`NUM_PE-1]] = touch[label[`NUM_PE-1]] || (growth[`NUM_PE] == 2);
            growing = 1'b0;
            for (int k = 0; k < `NUM_PE; k++) begin
                unit_odd[k] = parity[label[k]] && !touch[label[k]];
                growing     = growing || unit_odd[k];
            end
            if (growing) begin
                rounds++;
                // Half step per odd unit on each of its two edges
                for (int k = 0; k < `NUM_PE; k++) begin
                    if (unit_odd[k] && growth[k] < 2) begin
                        growth[k]++;
                    end
                    if (unit_odd[k] && growth[k+1] < 2) begin
                        growth[k+1]++;
                    end
                end
            end
        end
        for (int k = 0; k < `NUM_PE; k++) begin
            exp_roots[k*`ADDR_WIDTH +: `ADDR_WIDTH] = `ADDR_WIDTH'(label[k]);
        end
        for (int e = 0; e <= `NUM_PE; e++) begin
            exp_edges[e] = (growth[e] == 2);
        end
        exp_rounds = `ROUND_WIDTH'(rounds);
    endtask

    task automatic launch_run(input logic [`NUM_PE-1:0] syn);
        @(posedge clk);
        syndrome <= syn;
        start    <= 1'b1;
        @(posedge clk);
        start    <= 1'b0;
        @(negedge clk);
        assert (!done) else begin
            $display("ERR %0t: done still high after start was accepted", $time);
            stop_on_failure();
        end
    endtask

    task automatic wait_for_done;
        int cycles;
        cycles = 0;
        while (!done && cycles < DONE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Timeout: done never arrived within %0d cycles", DONE_LIMIT);
            stop_on_failure();
        end
    endtask

    // Returns once the running decode has counted its first grow round
    task automatic wait_for_first_round;
        int cycles;
        cycles = 0;
        while (grow_rounds == '0 && !done && cycles < DONE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (grow_rounds == '0 || done) begin
            $display("No grow round was seen while the run was still going");
            stop_on_failure();
        end
    endtask

    // The aborted run must not come back to done on its own
    task automatic check_stays_idle(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk);
            assert (!done && grow_rounds == '0) else begin
                $display("ERR %0t: reset during a run left done or grow_rounds set", $time);
                stop_on_failure();
            end
        end
    endtask

    task automatic check_results(input logic [`NUM_PE-1:0] syn, input string name);
        predict(syn);
        assert (roots == exp_roots) else begin
            $display("ERR %0t: %s roots %h, expected %h", $time, name, roots, exp_roots);
            stop_on_failure();
        end
        assert (grown_edges == exp_edges) else begin
            $display("ERR %0t: %s grown_edges %b, expected %b", $time, name,
                     grown_edges, exp_edges);
            stop_on_failure();
        end
        assert (grow_rounds == exp_rounds) else begin
            $display("ERR %0t: %s grow_rounds %0d, expected %0d", $time, name,
                     grow_rounds, exp_rounds);
            stop_on_failure();
        end
    endtask

    task automatic decode_and_check(input logic [`NUM_PE-1:0] syn, input string name);
        launch_run(syn);
        wait_for_done();
        check_results(syn, name);
    endtask

    initial begin
        logic [31:0]                    rand_word;
        logic [`NUM_PE*`ADDR_WIDTH-1:0] own_roots;
        void'($urandom(70));
        reset    = 1'b1;
        start    = 1'b0;
        syndrome = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!done && grow_rounds == '0) else begin
            $display("ERR %0t: done or grow_rounds not cleared after reset", $time);
            stop_on_failure();
        end

        // Nothing odd, so every unit stays its own root
        for (int k = 0; k < `NUM_PE; k++) begin
            own_roots[k*`ADDR_WIDTH +: `ADDR_WIDTH] = `ADDR_WIDTH'(k);
        end
        decode_and_check(8'h00, "zero syndrome");
        assert (grow_rounds == '0 && grown_edges == '0 && roots == own_roots) else begin
            $display("ERR %0t: zero syndrome did not finish untouched", $time);
            stop_on_failure();
        end

        // Units 3 and 4 meet on edge 4 in one round
        decode_and_check(8'h18, "adjacent pair");
        assert (grown_edges[4] && grow_rounds == `ROUND_WIDTH'(1)
                && roots[3*`ADDR_WIDTH +: `ADDR_WIDTH] == `ADDR_WIDTH'(3)
                && roots[4*`ADDR_WIDTH +: `ADDR_WIDTH] == `ADDR_WIDTH'(3)) else begin
            $display("ERR %0t: adjacent pair did not merge on edge 4", $time);
            stop_on_failure();
        end

        decode_and_check(8'h01, "left boundary");
        assert (grown_edges[0]) else begin
            $display("ERR %0t: edge 0 not grown for a defect at unit 0", $time);
            stop_on_failure();
        end

        for (int run = 0; run < RANDOM_RUNS; run++) begin
            rand_word = $urandom;
            decode_and_check(rand_word[`NUM_PE-1:0], "random");
        end

        // New start while the previous results are still shown
        assert (done) else begin
            $display("ERR %0t: done not held between runs", $time);
            stop_on_failure();
        end
        decode_and_check(8'ha6, "restart from done");

        // Reset in the middle of a run, once a grow round has been counted
        launch_run(8'h81);
        wait_for_first_round();
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        check_stays_idle(IDLE_CYCLES);
        decode_and_check(8'h81, "after reset");

        $display("No errors");
        $finish;
    end

endmodule

/* union_find_decoder.f */
+incdir+src
src/uf_pkg.sv
src/stage_controller.sv
src/round_timer.sv
src/root_min_select.sv
src/processing_unit.sv
src/edge_support.sv
src/decoder_array.sv
verification/decoder_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the decoder array with its testbench and run the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module decoder_tb \
    -f union_find_decoder.f -o decoder_sim &&
    ./obj_dir/decoder_sim ||
    exit 1
